// ==== Makefile ====
SIM      ?= verilator
TOP      ?= tb_mips_core
FILELIST ?= verilog.f
BUILD    ?= obj_dir
FLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  mips_pkg::alu_op_t alu_op,
    input  mips_pkg::word_t   data_in1,
    input  mips_pkg::word_t   data_in2,
    input  mips_pkg::word_t   imm_value,
    input  logic              use_imm,
    input  mips_pkg::shamt_t  shamt,
    output mips_pkg::word_t   data_out,
    output logic              zero
);
    import mips_pkg::*;

    word_t  op_b;
    shamt_t var_shamt;

    assign op_b      = use_imm ? imm_value : data_in2;
    assign var_shamt = data_in1[4:0]; // variable shifts take rs modulo 32.

    always_comb
    begin
        case (alu_op)
            xor_op:  data_out = data_in1 ^ op_b;
            sll_op:  data_out = op_b << shamt;
            sllv_op: data_out = op_b << var_shamt;
            srl_op:  data_out = op_b >> shamt;
            srlv_op: data_out = op_b >> var_shamt;
            sra_op:  data_out = word_t'($signed(op_b) >>> shamt);
            add_op:  data_out = data_in1 + op_b;
            sub_op:  data_out = data_in1 - op_b;
            mult_op: data_out = data_in1 * op_b; // only the low word is kept.
            div_op:  data_out = data_in1 % op_b; // unsigned remainder.
            or_op:   data_out = data_in1 | op_b;
            nor_op:  data_out = ~(data_in1 | op_b);
            and_op:  data_out = data_in1 & op_b;
            slt_op:  data_out = word_t'($signed(data_in1) < $signed(op_b));
            lui_op:  data_out = {op_b[15:0], 16'h0000};
            beq_op:  data_out = word_t'(data_in1 == op_b);
            bne_op:  data_out = word_t'(data_in1 != op_b);
            blez_op:
            begin
                data_out = word_t'(data_in1[31] || (data_in1 == '0));
            end
            bgtz_op:
            begin
                data_out = word_t'(!data_in1[31] && (data_in1 != '0));
            end
            bgez_op: data_out = word_t'(!data_in1[31]);
            jr_op:   data_out = '0; // the jump target is taken from rs by the pc logic.
            default: data_out = '0;
        endcase
    end

    // Branches are taken when the result is nonzero, so the zero flag clear means taken.
    assign zero = (data_out == '0);

endmodule

`default_nettype wire

// ==== hdl/control_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_fsm (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::word_t     instr,
    input  mips_pkg::word_t     alu_result,
    input  logic                zero,
    output mips_pkg::reg_addr_t rs_addr,
    output mips_pkg::reg_addr_t rt_addr,
    output mips_pkg::alu_op_t   alu_op,
    output mips_pkg::shamt_t    shamt,
    output mips_pkg::word_t     imm_value,
    output logic                use_imm,
    output logic                wb_en,
    output mips_pkg::reg_addr_t wb_addr,
    output mips_pkg::word_t     wb_data,
    output logic                pc_step,
    output logic                branch,
    output logic                branch_cond,
    output logic                jump,
    output logic                jump_reg,
    output logic [25:0]         jump_index,
    output logic                halted
);
    import mips_pkg::*;

    state_t     state;
    word_t      ir;
    word_t      result_q;
    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  dest;
    logic       writes_reg;
    logic       zext;
    logic       is_syscall;

    assign opcode     = ir[31:26];
    assign funct      = ir[5:0];
    assign rs_addr    = ir[25:21];
    assign rt_addr    = ir[20:16];
    assign shamt      = ir[10:6];
    assign jump_index = ir[25:0];
    assign imm_value  = zext ? {16'h0000, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};

    always_comb
    begin
        alu_op     = sll_op;
        use_imm    = 1'b0;
        zext       = 1'b0;
        writes_reg = 1'b0;
        dest       = ir[15:11]; // rd unless an immediate form picks rt.
        branch     = 1'b0;
        jump       = 1'b0;
        jump_reg   = 1'b0;
        is_syscall = 1'b0;
        case (opcode)
            op_rtype:
            begin
                writes_reg = 1'b1;
                case (funct)
                    fn_sll:           alu_op = sll_op;
                    fn_srl:           alu_op = srl_op;
                    fn_sra:           alu_op = sra_op;
                    fn_sllv:          alu_op = sllv_op;
                    fn_srlv:          alu_op = srlv_op;
                    fn_mult:          alu_op = mult_op;
                    fn_div:           alu_op = div_op;
                    fn_add, fn_addu:  alu_op = add_op;
                    fn_sub, fn_subu:  alu_op = sub_op;
                    fn_and:           alu_op = and_op;
                    fn_or:            alu_op = or_op;
                    fn_xor:           alu_op = xor_op;
                    fn_nor:           alu_op = nor_op;
                    fn_slt:           alu_op = slt_op;
                    fn_jr:
                    begin
                        alu_op     = jr_op;
                        writes_reg = 1'b0;
                        jump_reg   = 1'b1;
                    end
                    fn_syscall:
                    begin
                        writes_reg = 1'b0;
                        is_syscall = 1'b1;
                    end
                    default:          writes_reg = 1'b0; // unknown funct retires as a no-op.
                endcase
            end
            op_addi, op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui:
            begin
                use_imm    = 1'b1;
                writes_reg = 1'b1;
                dest       = ir[20:16];
                zext       = (opcode == op_andi) || (opcode == op_ori) || (opcode == op_xori);
                case (opcode)
                    op_slti: alu_op = slt_op;
                    op_andi: alu_op = and_op;
                    op_ori:  alu_op = or_op;
                    op_xori: alu_op = xor_op;
                    op_lui:  alu_op = lui_op;
                    default: alu_op = add_op;
                endcase
            end
            op_beq:
            begin
                alu_op = beq_op;
                branch = 1'b1;
            end
            op_bne:
            begin
                alu_op = bne_op;
                branch = 1'b1;
            end
            op_blez:
            begin
                alu_op = blez_op;
                branch = 1'b1;
            end
            op_bgtz:
            begin
                alu_op = bgtz_op;
                branch = 1'b1;
            end
            op_regimm:
            begin
                alu_op = bgez_op;
                branch = (ir[20:16] == 5'd1); // only bgez is decoded here.
            end
            op_j:    jump = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= st_fetch;
        else
        begin
            case (state)
                st_fetch:     state <= st_decode;
                st_decode:    state <= is_syscall ? st_halt : st_execute;
                st_execute:   state <= st_writeback;
                st_writeback: state <= st_fetch;
                default:      state <= st_halt; // halt holds until reset.
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            ir <= '0;
        else if (state == st_fetch)
            ir <= instr;
    end

    always_ff @(posedge clk)
    begin
        if (state == st_execute)
            result_q <= alu_result;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            branch_cond <= 1'b0;
        else if (state == st_execute)
            branch_cond <= ~zero;
    end

    assign wb_en   = (state == st_writeback) && writes_reg;
    assign wb_addr = dest;
    assign wb_data = result_q;
    assign pc_step = (state == st_writeback);
    assign halted  = (state == st_halt);

endmodule

`default_nettype wire

// ==== hdl/mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::word_t     instr,
    output mips_pkg::word_t     pc,
    output logic                wb_en,
    output mips_pkg::reg_addr_t wb_addr,
    output mips_pkg::word_t     wb_data,
    output logic                halted,
    output mips_pkg::word_t     retired
);
    import mips_pkg::*;

    reg_addr_t   rs_addr;
    reg_addr_t   rt_addr;
    word_t       rs_data;
    word_t       rt_data;
    alu_op_t     alu_op;
    shamt_t      shamt;
    word_t       imm_value;
    logic        use_imm;
    word_t       alu_result;
    logic        zero;
    logic        pc_step;
    logic        branch;
    logic        branch_cond;
    logic        jump;
    logic        jump_reg;
    logic [25:0] jump_index;

    control_fsm control_fsm_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .alu_result  (alu_result),
        .zero        (zero),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .alu_op      (alu_op),
        .shamt       (shamt),
        .imm_value   (imm_value),
        .use_imm     (use_imm),
        .wb_en       (wb_en),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .pc_step     (pc_step),
        .branch      (branch),
        .branch_cond (branch_cond),
        .jump        (jump),
        .jump_reg    (jump_reg),
        .jump_index  (jump_index),
        .halted      (halted)
    );

    reg_file reg_file_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    alu alu_inst (
        .alu_op    (alu_op),
        .data_in1  (rs_data),
        .data_in2  (rt_data),
        .imm_value (imm_value),
        .use_imm   (use_imm),
        .shamt     (shamt),
        .data_out  (alu_result),
        .zero      (zero)
    );

    pc_counter pc_counter_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc_step     (pc_step),
        .branch      (branch),
        .branch_cond (branch_cond),
        .jump        (jump),
        .jump_reg    (jump_reg),
        .jump_index  (jump_index),
        .imm_value   (imm_value),
        .rs_data     (rs_data),
        .pc          (pc),
        .retired     (retired)
    );

endmodule

`default_nettype wire

// ==== hdl/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [4:0]  alu_op_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_writeback,
        st_halt
    } state_t;

    localparam alu_op_t xor_op  = 5'b00000;
    localparam alu_op_t sll_op  = 5'b00001;
    localparam alu_op_t sllv_op = 5'b11001;
    localparam alu_op_t srl_op  = 5'b00010;
    localparam alu_op_t srlv_op = 5'b11010;
    localparam alu_op_t sra_op  = 5'b00011;
    localparam alu_op_t add_op  = 5'b00100;
    localparam alu_op_t sub_op  = 5'b00101;
    localparam alu_op_t mult_op = 5'b00110;
    localparam alu_op_t div_op  = 5'b00111;
    localparam alu_op_t or_op   = 5'b01000;
    localparam alu_op_t nor_op  = 5'b01001;
    localparam alu_op_t and_op  = 5'b01010;
    localparam alu_op_t slt_op  = 5'b01011;
    localparam alu_op_t jr_op   = 5'b01100;
    localparam alu_op_t beq_op  = 5'b01101;
    localparam alu_op_t bne_op  = 5'b01110;
    localparam alu_op_t blez_op = 5'b01111;
    localparam alu_op_t bgtz_op = 5'b10000;
    localparam alu_op_t bgez_op = 5'b10001;
    localparam alu_op_t lui_op  = 5'b10010;

    localparam logic [5:0] op_rtype  = 6'h00;
    localparam logic [5:0] op_regimm = 6'h01; // rt field 1 selects bgez.
    localparam logic [5:0] op_j      = 6'h02;
    localparam logic [5:0] op_beq    = 6'h04;
    localparam logic [5:0] op_bne    = 6'h05;
    localparam logic [5:0] op_blez   = 6'h06;
    localparam logic [5:0] op_bgtz   = 6'h07;
    localparam logic [5:0] op_addi   = 6'h08;
    localparam logic [5:0] op_addiu  = 6'h09;
    localparam logic [5:0] op_slti   = 6'h0a;
    localparam logic [5:0] op_andi   = 6'h0c;
    localparam logic [5:0] op_ori    = 6'h0d;
    localparam logic [5:0] op_xori   = 6'h0e;
    localparam logic [5:0] op_lui    = 6'h0f;

    localparam logic [5:0] fn_sll     = 6'h00;
    localparam logic [5:0] fn_srl     = 6'h02;
    localparam logic [5:0] fn_sra     = 6'h03;
    localparam logic [5:0] fn_sllv    = 6'h04;
    localparam logic [5:0] fn_srlv    = 6'h06;
    localparam logic [5:0] fn_jr      = 6'h08;
    localparam logic [5:0] fn_syscall = 6'h0c;
    localparam logic [5:0] fn_mult    = 6'h18;
    localparam logic [5:0] fn_div     = 6'h1a;
    localparam logic [5:0] fn_add     = 6'h20;
    localparam logic [5:0] fn_addu    = 6'h21;
    localparam logic [5:0] fn_sub     = 6'h22;
    localparam logic [5:0] fn_subu    = 6'h23;
    localparam logic [5:0] fn_and     = 6'h24;
    localparam logic [5:0] fn_or      = 6'h25;
    localparam logic [5:0] fn_xor     = 6'h26;
    localparam logic [5:0] fn_nor     = 6'h27;
    localparam logic [5:0] fn_slt     = 6'h2a;

    localparam word_t reset_pc = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== hdl/pc_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_counter (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            pc_step,
    input  logic            branch,
    input  logic            branch_cond,
    input  logic            jump,
    input  logic            jump_reg,
    input  logic [25:0]     jump_index,
    input  mips_pkg::word_t imm_value,
    input  mips_pkg::word_t rs_data,
    output mips_pkg::word_t pc,
    output mips_pkg::word_t retired
);
    import mips_pkg::*;

    word_t pc_plus4;
    word_t pc_next;

    assign pc_plus4 = pc + 32'd4;

    always_comb
    begin
        if (jump_reg)
            pc_next = rs_data;
        else if (jump)
            pc_next = {pc_plus4[31:28], jump_index, 2'b00};
        else if (branch && branch_cond)
            pc_next = pc_plus4 + {imm_value[29:0], 2'b00}; // no delay slot.
        else
            pc_next = pc_plus4;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pc      <= reset_pc;
            retired <= '0;
        end
        else if (pc_step)
        begin
            pc      <= pc_next;
            retired <= retired + 32'd1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::reg_addr_t rs_addr,
    input  mips_pkg::reg_addr_t rt_addr,
    input  logic                wb_en,
    input  mips_pkg::reg_addr_t wb_addr,
    input  mips_pkg::word_t     wb_data,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data
);
    import mips_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb_en && (wb_addr != '0))
        begin
            regs[wb_addr] <= wb_data; // writes to $zero are dropped.
        end
    end

    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

// ==== verif/mips_core_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core_asserts (
    input logic            clk,
    input logic            rst_n,
    input logic            wb_en,
    input logic            halted,
    input logic            pc_step,
    input mips_pkg::word_t pc
);

    wb_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        wb_en |=> !wb_en)
        else $error("wb_en stayed high for more than one cycle.");

    no_write_halted: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> !wb_en)
        else $error("wb_en rose while the core was halted.");

    // halt only ends with a reset.
    halt_holds: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted)
        else $error("halted dropped without a reset.");

    pc_after_wb: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(pc) |-> $past(pc_step))
        else $error("pc changed outside the cycle after a writeback.");

endmodule

`default_nettype wire

// ==== verif/tb_mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;
    import mips_pkg::*;

    logic       clk;
    logic       rst_n;
    word_t      instr;
    word_t      pc;
    logic       wb_en;
    reg_addr_t  wb_addr;
    word_t      wb_data;
    logic       halted;
    word_t      retired;

    word_t      imem [64];
    word_t      ref_regs [32];
    word_t      ref_pc;
    word_t      fetch_pc;
    word_t      exp_count;
    logic       exp_wb_en;
    reg_addr_t  exp_wb_addr;
    word_t      exp_wb_data;
    logic       exp_halted;
    logic       halt_next;
    logic [2:0] phase;           // 0 to 3 follow fetch to writeback, 4 means idle.
    int         prog_len;
    int         cycle_limit;
    int         cycles;
    integer     seed;
    logic       stopped;
    word_t      rnd;
    shamt_t     sa;

    mips_core mips_core_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .instr   (instr),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .halted  (halted),
        .retired (retired)
    );

    bind mips_core mips_core_asserts mips_core_asserts_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_en   (wb_en),
        .halted  (halted),
        .pc_step (pc_step),
        .pc      (pc)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(negedge clk)
    begin
        instr <= imem[pc[7:2]]; // the word at the current pc answers within the fetch cycle.
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit)
            fail_run($sformatf("timeout after %0d cycles without the core halting", cycles));
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic value_mismatch(input string name, input word_t expected, input word_t actual);
        fail_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
    endtask

    function automatic word_t enc_r(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd, shamt_t shamt,
                                    logic [5:0] fn);
        return {op_rtype, rs, rt, rd, shamt, fn};
    endfunction

    function automatic word_t enc_i(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                    logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic emit(input word_t iw);
        imem[prog_len] = iw;
        prog_len = prog_len + 1;
    endtask

    // Every branch jumps over one filler word when it is taken.
    task automatic emit_branch(input word_t iw);
        emit(iw);
        emit(enc_i(op_addi, 5'd0, 5'd21, 16'(prog_len)));
    endtask

    task automatic step_model(input word_t iw);
        logic [5:0] op;
        logic [5:0] fn;
        reg_addr_t  rt;
        shamt_t     shamt;
        word_t      a;
        word_t      b;
        word_t      simm;
        word_t      zimm;
        word_t      pc4;
        word_t      next_pc;
        logic       take;
        op          = iw[31:26];
        fn          = iw[5:0];
        rt          = iw[20:16];
        shamt       = iw[10:6];
        a           = ref_regs[iw[25:21]];
        b           = ref_regs[rt];
        simm        = {{16{iw[15]}}, iw[15:0]};
        zimm        = {16'h0000, iw[15:0]};
        pc4         = fetch_pc + 32'd4;
        next_pc     = pc4;
        take        = 1'b0;
        halt_next   = 1'b0;
        exp_wb_en   = 1'b1;
        exp_wb_addr = (op == op_rtype) ? iw[15:11] : rt;
        exp_wb_data = '0;
        case (op)
            op_rtype:
            begin
                case (fn)
                    fn_sll:          exp_wb_data = b << shamt;
                    fn_srl:          exp_wb_data = b >> shamt;
                    fn_sra:          exp_wb_data = $signed(b) >>> shamt;
                    fn_sllv:         exp_wb_data = b << a[4:0];
                    fn_srlv:         exp_wb_data = b >> a[4:0];
                    fn_add, fn_addu: exp_wb_data = a + b;
                    fn_sub, fn_subu: exp_wb_data = a - b;
                    fn_mult:         exp_wb_data = a * b;
                    fn_div:          exp_wb_data = a % b;
                    fn_and:          exp_wb_data = a & b;
                    fn_or:           exp_wb_data = a | b;
                    fn_xor:          exp_wb_data = a ^ b;
                    fn_nor:          exp_wb_data = ~(a | b);
                    fn_slt:          exp_wb_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    fn_jr:
                    begin
                        exp_wb_en = 1'b0;
                        next_pc   = a;
                    end
                    fn_syscall:
                    begin
                        exp_wb_en = 1'b0;
                        halt_next = 1'b1;
                    end
                    default:         exp_wb_en = 1'b0;
                endcase
            end
            op_addi, op_addiu: exp_wb_data = a + simm;
            op_slti:   exp_wb_data = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            op_andi:   exp_wb_data = a & zimm;
            op_ori:    exp_wb_data = a | zimm;
            op_xori:   exp_wb_data = a ^ zimm;
            op_lui:    exp_wb_data = {iw[15:0], 16'h0000};
            default:
            begin
                exp_wb_en = 1'b0;
                case (op)
                    op_beq:    take = (a == b);
                    op_bne:    take = (a != b);
                    op_blez:   take = ($signed(a) <= 0);
                    op_bgtz:   take = ($signed(a) > 0);
                    op_regimm: take = (rt == 5'd1) && ($signed(a) >= 0);
                    op_j:      next_pc = {pc4[31:28], iw[25:0], 2'b00};
                    default:   take = 1'b0;
                endcase
            end
        endcase
        if (take)
            next_pc = pc4 + (simm << 2);
        if (exp_wb_en && (exp_wb_addr != 5'd0))
            ref_regs[exp_wb_addr] = exp_wb_data;
        if (!halt_next)
        begin
            ref_pc    = next_pc;
            exp_count = exp_count + 32'd1;
        end
    endtask

    task automatic build_program();
        for (int i = 0; i < 64; i++)
            imem[i] = enc_i(op_addiu, 5'd0, 5'd0, 16'(i));
        prog_len = 0;
        rnd = $random(seed);
        emit(enc_i(op_lui, 5'd0, 5'd1, rnd[31:16]));
        emit(enc_i(op_ori, 5'd1, 5'd1, rnd[15:0]));
        rnd = $random(seed);
        emit(enc_i(op_lui, 5'd0, 5'd2, rnd[31:16]));
        emit(enc_i(op_ori, 5'd2, 5'd2, rnd[15:0]));
        rnd = $random(seed);
        sa = rnd[20:16];
        emit(enc_i(op_addi, 5'd0, 5'd3, {rnd[15:1], 1'b1})); // odd, so never a zero divisor.
        emit(enc_i(op_addiu, 5'd0, 5'd4, 16'hfffb));
        emit(enc_i(op_addi, 5'd0, 5'd10, 16'd7));
        emit(enc_r(5'd1, 5'd2, 5'd5, 5'd0, fn_add));
        emit(enc_r(5'd2, 5'd3, 5'd5, 5'd0, fn_addu));
        emit(enc_r(5'd1, 5'd2, 5'd6, 5'd0, fn_sub));
        emit(enc_r(5'd3, 5'd4, 5'd6, 5'd0, fn_subu));
        emit(enc_r(5'd1, 5'd2, 5'd7, 5'd0, fn_mult));
        emit(enc_r(5'd1, 5'd3, 5'd8, 5'd0, fn_div));
        emit(enc_r(5'd1, 5'd2, 5'd9, 5'd0, fn_and));
        emit(enc_r(5'd1, 5'd2, 5'd11, 5'd0, fn_or));
        emit(enc_r(5'd1, 5'd2, 5'd12, 5'd0, fn_xor));
        emit(enc_r(5'd1, 5'd2, 5'd13, 5'd0, fn_nor));
        emit(enc_r(5'd1, 5'd2, 5'd14, 5'd0, fn_slt));
        emit(enc_r(5'd4, 5'd0, 5'd14, 5'd0, fn_slt));
        emit(enc_r(5'd10, 5'd10, 5'd14, 5'd0, fn_slt)); // equal operands give 0.
        emit(enc_r(5'd0, 5'd1, 5'd15, sa, fn_sll));
        emit(enc_r(5'd0, 5'd1, 5'd15, sa, fn_srl));
        emit(enc_r(5'd0, 5'd4, 5'd15, sa, fn_sra));
        emit(enc_r(5'd3, 5'd2, 5'd16, 5'd0, fn_sllv));
        emit(enc_r(5'd3, 5'd2, 5'd16, 5'd0, fn_srlv));
        emit(enc_i(op_slti, 5'd4, 5'd17, 16'hffff));
        emit(enc_i(op_andi, 5'd4, 5'd17, 16'hf0f0));
        emit(enc_i(op_xori, 5'd4, 5'd18, 16'h8001));
        emit(enc_i(op_addi, 5'd1, 5'd19, 16'h8000));
        emit(enc_i(op_addi, 5'd0, 5'd0, 16'd5));
        emit(enc_r(5'd0, 5'd10, 5'd20, 5'd0, fn_add)); // r0 must still read zero here.
        emit_branch(enc_i(op_beq, 5'd1, 5'd1, 16'd1));
        emit_branch(enc_i(op_beq, 5'd1, 5'd10, 16'd1));
        emit_branch(enc_i(op_bne, 5'd1, 5'd10, 16'd1));
        emit_branch(enc_i(op_bne, 5'd10, 5'd10, 16'd1));
        emit_branch(enc_i(op_blez, 5'd4, 5'd0, 16'd1));
        emit_branch(enc_i(op_blez, 5'd10, 5'd0, 16'd1));
        emit_branch(enc_i(op_bgtz, 5'd10, 5'd0, 16'd1));
        emit_branch(enc_i(op_bgtz, 5'd0, 5'd0, 16'd1));
        emit_branch(enc_i(op_regimm, 5'd0, 5'd1, 16'd1));
        emit_branch(enc_i(op_regimm, 5'd4, 5'd1, 16'd1));
        emit({op_j, 26'(prog_len + 2)});
        emit(enc_i(op_addi, 5'd0, 5'd21, 16'hdead));
        emit(enc_i(op_addi, 5'd0, 5'd22, 16'((prog_len + 3) * 4)));
        emit(enc_r(5'd22, 5'd0, 5'd0, 5'd0, fn_jr));
        emit(enc_i(op_addi, 5'd0, 5'd21, 16'hdead));
        emit(enc_r(5'd0, 5'd0, 5'd0, 5'd0, fn_syscall));
    endtask

    wb_en_match: assert property (@(posedge clk) disable iff (!rst_n)
        (phase == 3'd3) |-> (wb_en == exp_wb_en))
        else value_mismatch("wb_en", word_t'($sampled(exp_wb_en)), word_t'($sampled(wb_en)));
    wb_en_placed: assert property (@(posedge clk) disable iff (!rst_n)
        (phase != 3'd3) |-> !wb_en)
        else fail_run("wb_en pulsed outside a writeback cycle");
    wb_addr_match: assert property (@(posedge clk) disable iff (!rst_n)
        wb_en |-> (wb_addr == exp_wb_addr))
        else value_mismatch("wb_addr", word_t'($sampled(exp_wb_addr)),
                            word_t'($sampled(wb_addr)));
    wb_data_match: assert property (@(posedge clk) disable iff (!rst_n)
        wb_en |-> (wb_data == exp_wb_data))
        else value_mismatch("wb_data", $sampled(exp_wb_data), $sampled(wb_data));
    pc_match: assert property (@(posedge clk) disable iff (!rst_n)
        (phase == 3'd0) |-> (pc == fetch_pc))
        else value_mismatch("pc", $sampled(fetch_pc), $sampled(pc));
    halted_match: assert property (@(posedge clk) disable iff (!rst_n)
        halted == exp_halted)
        else value_mismatch("halted", word_t'($sampled(exp_halted)), word_t'($sampled(halted)));

    initial
    begin
        seed        = 32'hac95_1143;
        rst_n       = 1'b0;
        instr       = '0;
        phase       = 3'd4;
        cycles      = 0;
        ref_pc      = reset_pc;
        fetch_pc    = reset_pc;
        exp_count   = '0;
        exp_wb_en   = 1'b0;
        exp_wb_addr = '0;
        exp_wb_data = '0;
        exp_halted  = 1'b0;
        halt_next   = 1'b0;
        stopped     = 1'b0;
        for (int i = 0; i < 32; i++)
            ref_regs[i] = '0;
        build_program();
        cycle_limit = 4 * prog_len + 50;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        assert (pc == reset_pc) else value_mismatch("pc", reset_pc, pc);
        assert (!wb_en) else value_mismatch("wb_en", '0, word_t'(wb_en));
        assert (!halted) else value_mismatch("halted", '0, word_t'(halted));
        while (!stopped)
        begin
            fetch_pc = ref_pc;
            step_model(imem[fetch_pc[7:2]]);
            phase = 3'd0;
            @(negedge clk);
            phase = 3'd1;
            @(negedge clk);
            if (halt_next)
            begin
                phase      = 3'd4;
                exp_halted = 1'b1;
                stopped    = 1'b1;
            end
            else
            begin
                phase = 3'd2;
                @(negedge clk);
                phase = 3'd3;
                @(negedge clk);
            end
        end
        repeat (4) @(negedge clk); // the stopped core must stay quiet.
        if (retired != exp_count)
            value_mismatch("retired", exp_count, retired);
        else
        begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/mips_pkg.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/control_fsm.sv
hdl/pc_counter.sv
hdl/mips_core.sv
verif/mips_core_asserts.sv
verif/tb_mips_core.sv
